// File: filelist.f
+incdir+testbench
design/fetch_pkg.sv
design/fetch_pc.sv
design/jump_predecode.sv
design/jump_handler.sv
design/fetch_frontend.sv
testbench/tb_fetch_frontend.sv

// File: Makefile
# Verilator build and run for the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timescale 1ns/100ps
PASS_MSG  ?= Finished with no errors

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_fetch_tasks.svh
///////////////////////////////
// timing and checks
///////////////////////////////

// drive point, 1 ns after the edge
task automatic cycle();
   @(posedge clk);
   #1;
endtask

// outputs stable, well before the next edge
task automatic settle();
   #2;
endtask

task automatic abort_run(input string why);
   $display("%s (at %0t)", why, $time);
   $display("Finished with errors");
   $fatal(1, "stopping at first failure");
endtask

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
   if (actual !== expected) begin
      $display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      abort_run("output did not match the expected value");
   end
endtask

// back end redirect, used to park fetch at a known pc
task automatic jump_to(input word_t addr);
   mispredict    = 1'b1;
   mispredict_pc = addr;
   cycle();
   mispredict    = 1'b0;
endtask

// returns at a settled point with jump_valid high
task automatic wait_jump_valid(input int limit, output int waited);
   waited = 0;
   settle();
   while (jump_valid !== 1'b1 && waited < limit) begin
      cycle();
      settle();
      waited++;
   end
   if (jump_valid !== 1'b1) begin
      abort_run($sformatf("jump_valid never rose within %0d cycles", limit));
   end
endtask

// jump encodings, opcode on top
function automatic word_t imm_word(input logic [9:0] disp);
   return {JUMP_OPCODE, disp, 2'b00};
endfunction

function automatic word_t base_word(input logic [5:0] ofs);
   return {JUMP_OPCODE, 4'h0, ofs, 2'b01};
endfunction

task automatic restore_word(input word_t addr);
   mem[addr] = fill_word(addr);
endtask

///////////////////////////////
// directed tests
///////////////////////////////

// plain +4 steps from reset
task automatic sequential_fetch(input int bundles);
   settle();
   check_value("imem_addr", 32'(imem_addr), 32'(RESET_PC));
   for (int i = 1; i <= bundles; i++) begin
      cycle();
      settle();
      check_value("imem_addr", 32'(imem_addr), 32'(word_t'(RESET_PC + 4 * i)));
      check_value("jump_valid", 32'(jump_valid), 32'd0);
      check_value("stall", 32'(stall), 32'd0);
   end
   cycle();
endtask

// second < 0 means a single jump
task automatic immediate_jump(input word_t pc, input int slot, input logic [9:0] disp,
                              input int second);
   word_t target;
   // next instruction plus sign extended displacement
   target = pc + word_t'(slot) + 16'd1 + {{6{disp[9]}}, disp};
   mem[pc + word_t'(slot)] = imm_word(disp);
   if (second > slot) begin
      mem[pc + word_t'(second)] = imm_word(10'h155);
   end
   jump_to(pc);
   settle();
   check_value("imem_addr", 32'(imem_addr), 32'(pc));
   check_value("jump_valid", 32'(jump_valid), 32'd1);
   check_value("jump_target", 32'(jump_target), 32'(target));
   check_value("stall", 32'(stall), 32'd0);
   cycle();
   settle();
   check_value("imem_addr", 32'(imem_addr), 32'(target));
   check_value("jump_valid", 32'(jump_valid), 32'd0);
   restore_word(pc + word_t'(slot));
   restore_word(pc + word_t'(second));
   cycle();
endtask

// random wait before the base arrives
task automatic base_register_jump(input word_t pc, input int slot, input logic [5:0] ofs,
                                  input logic imm_after);
   word_t base;
   word_t target;
   int    delay;
   int    waited;
   delay  = $unsigned($random(seed)) % 7;
   // upper half, far from the jump bundles
   base   = {1'b1, 15'($random(seed))};
   target = base + {{10{ofs[5]}}, ofs};
   mem[pc + word_t'(slot)] = base_word(ofs);
   if (imm_after) begin
      mem[pc + word_t'(slot + 1)] = imm_word(10'h010);
   end
   jump_to(pc);
   settle();
   // detection cycle, pc held but no stall yet
   check_value("imem_addr", 32'(imem_addr), 32'(pc));
   check_value("jump_valid", 32'(jump_valid), 32'd0);
   check_value("stall", 32'(stall), 32'd0);
   cycle();
   for (int i = 0; i < delay; i++) begin
      settle();
      check_value("stall", 32'(stall), 32'd1);
      check_value("jump_valid", 32'(jump_valid), 32'd0);
      check_value("imem_addr", 32'(imem_addr), 32'(pc));
      cycle();
   end
   rf_base_valid = 1'b1;
   rf_base       = base;
   settle();
   check_value("stall", 32'(stall), 32'd1);
   check_value("jump_valid", 32'(jump_valid), 32'd0);
   cycle();
   rf_base_valid = 1'b0;
   rf_base       = ~base;
   wait_jump_valid(8, waited);
   check_value("base latency", 32'(waited), 32'd0);
   check_value("jump_target", 32'(jump_target), 32'(target));
   check_value("stall", 32'(stall), 32'd0);
   check_value("imem_addr", 32'(imem_addr), 32'(pc));
   cycle();
   settle();
   check_value("imem_addr", 32'(imem_addr), 32'(target));
   check_value("stall", 32'(stall), 32'd0);
   restore_word(pc + word_t'(slot));
   restore_word(pc + word_t'(slot + 1));
   cycle();
endtask

// mispredict in a base wait or in straight fetch
task automatic mispredict_recovery(input logic in_wait, input word_t pc, input word_t mpc);
   if (in_wait) begin
      mem[pc + 16'd2] = base_word(6'h0c);
   end
   // imm jump in the bundle the mispredict hits in straight fetch
   mem[pc + 16'd8] = imm_word(10'h040);
   jump_to(pc);
   cycle();
   settle();
   check_value("stall", 32'(stall), 32'(in_wait));
   cycle();
   mispredict    = 1'b1;
   mispredict_pc = mpc;
   settle();
   check_value("jump_valid", 32'(jump_valid), 32'd0);
   cycle();
   mispredict    = 1'b0;
   settle();
   check_value("imem_addr", 32'(imem_addr), 32'(mpc));
   check_value("stall", 32'(stall), 32'd0);
   restore_word(pc + 16'd2);
   restore_word(pc + 16'd8);
   // late base of an abandoned wait, dropped
   cycle();
   rf_base_valid = 1'b1;
   rf_base       = word_t'($random(seed));
   repeat (3) begin
      settle();
      check_value("jump_valid", 32'(jump_valid), 32'd0);
      check_value("stall", 32'(stall), 32'd0);
      cycle();
      rf_base_valid = 1'b0;
   end
endtask

// File: testbench/tb_fetch_frontend.sv
`timescale 1ns/100ps

module tb_fetch_frontend
   import fetch_pkg::*;
();

   logic         clk;
   logic         rst_n;
   fetch_words_t imem_rdata;
   word_t        rf_base;
   logic         rf_base_valid;
   logic         mispredict;
   word_t        mispredict_pc;
   word_t        imem_addr;
   logic         jump_valid;
   word_t        jump_target;
   logic         stall;

   // bases and wait delays come from here
   integer seed;

   ///////////////////////////////
   // clock and memory model
   ///////////////////////////////

   // 8 ns period
   always #4 clk = ~clk;

   // one word per address, full 64k space
   word_t mem [65536];

   // top bit clear, so never a jump
   function automatic word_t fill_word(input word_t addr);
      return {1'b0, addr[14:0] ^ {15{addr[15]}}};
   endfunction

   // combinational read, slot k from pc+k
   assign imem_rdata = {mem[word_t'(imem_addr + 16'd3)], mem[word_t'(imem_addr + 16'd2)],
                        mem[word_t'(imem_addr + 16'd1)], mem[imem_addr]};

   ///////////////////////////////
   // DUT
   ///////////////////////////////

   fetch_frontend i_fetch_frontend (
      .clk           (clk),
      .rst_n         (rst_n),
      .imem_rdata    (imem_rdata),
      .rf_base       (rf_base),
      .rf_base_valid (rf_base_valid),
      .mispredict    (mispredict),
      .mispredict_pc (mispredict_pc),
      .imem_addr     (imem_addr),
      .jump_valid    (jump_valid),
      .jump_target   (jump_target),
      .stall         (stall)
   );

   `include "tb_fetch_tasks.svh"

   ///////////////////////////////
   // test sequence
   ///////////////////////////////

   initial begin
      seed          = 3;
      clk           = 1'b0;
      rst_n         = 1'b0;
      rf_base       = '0;
      rf_base_valid = 1'b0;
      mispredict    = 1'b0;
      mispredict_pc = '0;
      for (int a = 0; a < 65536; a++) begin
         mem[a] = fill_word(word_t'(a));
      end
      // 10 edges in reset
      repeat (10) begin
         @(posedge clk);
      end
      #1;
      rst_n = 1'b1;

      sequential_fetch(8);
      // one immediate jump per slot, both directions
      immediate_jump(16'h0400, 0, 10'h3f0, -1);
      immediate_jump(16'h0800, 1, 10'h028, -1);
      immediate_jump(16'h0c00, 2, 10'h200, -1);
      immediate_jump(16'h1000, 3, 10'h1ff, -1);
      // two jumps, lower slot taken
      immediate_jump(16'h1400, 1, 10'h013, 3);
      base_register_jump(16'h2000, 0, 6'h05, 1'b0);
      base_register_jump(16'h2400, 3, 6'h3a, 1'b0);
      base_register_jump(16'h2800, 2, 6'h20, 1'b0);
      // imm right behind a base jump
      base_register_jump(16'h3000, 1, 6'h11, 1'b1);
      mispredict_recovery(1'b1, 16'h3400, 16'h5a52);
      mispredict_recovery(1'b0, 16'h3800, 16'h6c0c);

      $display("Finished with no errors");
      $finish;
   end

endmodule

// File: design/fetch_frontend.sv
`timescale 1ns/100ps

module fetch_frontend
   import fetch_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  fetch_words_t imem_rdata,
   input  word_t        rf_base,
   input  logic         rf_base_valid,
   input  logic         mispredict,
   input  word_t        mispredict_pc,
   output word_t        imem_addr,
   output logic         jump_valid,
   output word_t        jump_target,
   output logic         stall
);

   fetch_bundle_t bundle;
   slot_jump_t    slot_jump [SLOTS];
   redirect_t     redirect;

   ///////////////////////////////
   // pc and memory port
   ///////////////////////////////

   fetch_pc i_fetch_pc (
      .clk           (clk),
      .rst_n         (rst_n),
      .mispredict    (mispredict),
      .mispredict_pc (mispredict_pc),
      .redirect      (redirect),
      .imem_rdata    (imem_rdata),
      .imem_addr     (imem_addr),
      .bundle        (bundle)
   );

   ///////////////////////////////
   // one predecode per slot
   ///////////////////////////////

   for (genvar g = 0; g < SLOTS; g++) begin : g_slot
      jump_predecode #(
         .SLOT (g)
      ) i_jump_predecode (
         .bundle    (bundle),
         .slot_jump (slot_jump[g])
      );
   end

   // priority, base wait and redirect
   jump_handler i_jump_handler (
      .clk           (clk),
      .rst_n         (rst_n),
      .slot_jump     (slot_jump),
      .rf_base       (rf_base),
      .rf_base_valid (rf_base_valid),
      .mispredict    (mispredict),
      .redirect      (redirect),
      .stall         (stall)
   );

   // redirect seen from outside
   assign jump_valid  = redirect.valid;
   assign jump_target = redirect.target;

endmodule

// File: design/jump_handler.sv
`timescale 1ns/100ps

module jump_handler
   import fetch_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  slot_jump_t slot_jump [SLOTS],
   input  word_t      rf_base,
   input  logic       rf_base_valid,
   input  logic       mispredict,
   output redirect_t  redirect,
   output logic       stall
);

   ///////////////////////////////
   // slot priority
   ///////////////////////////////

   logic       hit;
   slot_idx_t  win_idx;
   slot_jump_t win;

   // scan from the top so the lowest slot wins
   always_comb begin
      hit     = 1'b0;
      win_idx = '0;
      for (int k = SLOTS - 1; k >= 0; k--) begin
         if (slot_jump[k].is_imm || slot_jump[k].is_base) begin
            hit     = 1'b1;
            win_idx = slot_idx_t'(k);
         end
      end
   end

   // later slots simply dropped
   assign win = slot_jump[win_idx];

   ///////////////////////////////
   // base wait FSM
   ///////////////////////////////

   handler_state_t state;
   handler_state_t state_nxt;

   // base already registered, redirect this cycle
   logic  base_rdy;
   logic  base_cap;
   logic  take_base;

   // latched offset of the winning base jump
   word_t offset_q;
   // returned register value
   word_t base_q;

   always_comb begin
      state_nxt = state;
      redirect  = '0;
      take_base = 1'b0;
      case (state)
         st_idle: begin
            if (hit) begin
               if (win.is_imm) begin
                  // redirect right away
                  redirect.valid  = 1'b1;
                  redirect.target = win.imm_target;
               end else begin
                  // hold this pc, wait for the base
                  redirect.hold = 1'b1;
                  take_base     = 1'b1;
                  state_nxt     = st_wait_base;
               end
            end
         end
         st_wait_base: begin
            if (base_rdy) begin
               redirect.valid  = 1'b1;
               redirect.target = base_q + offset_q;
               state_nxt       = st_idle;
            end else begin
               // bundles ignored while waiting
               redirect.hold = 1'b1;
            end
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
      // mispredict overrides any jump
      if (mispredict) begin
         redirect  = '0;
         take_base = 1'b0;
         state_nxt = st_idle;
      end
   end

   // only the first pulse in the wait counts
   assign base_cap = (state == st_wait_base) && !base_rdy && rf_base_valid && !mispredict;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_idle;
         base_rdy <= 1'b0;
      end else begin
         state    <= state_nxt;
         base_rdy <= base_cap;
      end
   end

   ///////////////////////////////
   // offset and base latches
   ///////////////////////////////

   always_ff @(posedge clk) begin
      if (mispredict) begin
         offset_q <= '0;
      end else if (take_base) begin
         offset_q <= win.base_offset;
      end
      if (base_cap) begin
         base_q <= rf_base;
      end
   end

   // stall from the edge after detection until the base is in
   assign stall = (state == st_wait_base) && !base_rdy;

endmodule

// File: design/jump_predecode.sv
`timescale 1ns/100ps

module jump_predecode
   import fetch_pkg::*;
#(
   // slot position inside the bundle
   parameter int unsigned SLOT = 0
) (
   input  fetch_bundle_t bundle,
   output slot_jump_t    slot_jump
);

   ///////////////////////////////
   // word select and decode
   ///////////////////////////////

   word_t      word;
   logic       is_jump;
   imm_field_t imm_field;
   ofs_field_t ofs_field;
   word_t      slot_pc;

   // this slice only looks at its own slot
   assign word = bundle.words[SLOT];

   // same opcode for both jump kinds
   assign is_jump = (word[15:12] == JUMP_OPCODE);

   // raw displacement fields
   assign imm_field = word[IMM_MSB:IMM_LSB];
   assign ofs_field = word[OFS_MSB:OFS_LSB];

   // address of this instruction
   assign slot_pc = bundle.pc + word_t'(SLOT);

   ///////////////////////////////
   // classification and targets
   ///////////////////////////////

   always_comb begin
      // bit 0 picks immediate or base
      slot_jump.is_imm  = is_jump && !word[0];
      slot_jump.is_base = is_jump && word[0];

      // pc relative, counted from the next instruction
      slot_jump.imm_target = slot_pc + 16'd1
                           + {{(16-$bits(imm_field_t)){imm_field[$high(imm_field)]}},
                              imm_field};

      // added to the register base later
      slot_jump.base_offset = {{(16-$bits(ofs_field_t)){ofs_field[$high(ofs_field)]}},
                               ofs_field};
   end

endmodule

// File: design/fetch_pc.sv
`timescale 1ns/100ps

module fetch_pc
   import fetch_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  logic          mispredict,
   input  word_t         mispredict_pc,
   input  redirect_t     redirect,
   input  fetch_words_t  imem_rdata,
   output word_t         imem_addr,
   output fetch_bundle_t bundle
);

   ///////////////////////////////
   // program counter
   ///////////////////////////////

   word_t pc;
   word_t pc_nxt;

   // next pc, highest priority first
   always_comb begin
      if (mispredict) begin
         // back end knows better
         pc_nxt = mispredict_pc;
      end else if (redirect.valid) begin
         // taken jump, imm or base
         pc_nxt = redirect.target;
      end else if (redirect.hold) begin
         // waiting on a base register
         pc_nxt = pc;
      end else begin
         // plain sequential bundle step
         pc_nxt = pc + word_t'(SLOTS);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= RESET_PC;
      end else begin
         pc <= pc_nxt;
      end
   end

   ///////////////////////////////
   // memory port and bundle
   ///////////////////////////////

   // combinational read, words come back this cycle
   assign imem_addr = pc;

   // pair current pc with its words
   always_comb begin
      bundle.pc    = pc;
      bundle.words = imem_rdata;
   end

endmodule

// File: design/fetch_pkg.sv
package fetch_pkg;

   ///////////////////////////////
   // widths and constants
   ///////////////////////////////

   // instruction word and pc share one width
   typedef logic [15:0] word_t;

   // instructions fetched per cycle
   localparam int unsigned SLOTS = 4;

   // slot number inside a bundle
   typedef logic [1:0] slot_idx_t;

   // all words of one bundle, slot k at pc+k
   typedef word_t [SLOTS-1:0] fetch_words_t;

   // top nibble of any jump
   localparam logic [3:0] JUMP_OPCODE = 4'b1111;

   // fetch starts here
   localparam word_t RESET_PC = 16'h0000;

   // immediate jump displacement field, bits 11..2
   localparam int unsigned IMM_MSB = 11;
   localparam int unsigned IMM_LSB = 2;
   typedef logic [IMM_MSB-IMM_LSB:0] imm_field_t;

   // base jump offset field, bits 7..2
   localparam int unsigned OFS_MSB = 7;
   localparam int unsigned OFS_LSB = 2;
   typedef logic [OFS_MSB-OFS_LSB:0] ofs_field_t;

   ///////////////////////////////
   // structs between blocks
   ///////////////////////////////

   // pc of slot 0 plus the words returned for it
   typedef struct packed {
      word_t        pc;
      fetch_words_t words;
   } fetch_bundle_t;

   // per-slot predecode result
   typedef struct packed {
      logic  is_imm;
      logic  is_base;
      word_t imm_target;
      word_t base_offset;
   } slot_jump_t;

   // handler back to pc block
   typedef struct packed {
      logic  valid;
      word_t target;
      logic  hold;
   } redirect_t;

   // jump handler FSM
   typedef enum logic {
      st_idle,
      st_wait_base
   } handler_state_t;

endpackage
